// File: src/vga_pkg.sv
package vga_pkg;

    localparam int CHANNEL_BITS  = 4;
    localparam int CHANNEL_COUNT = 4;
    localparam int WORD_BITS     = CHANNEL_BITS * CHANNEL_COUNT;
    localparam int SPAN_BITS     = WORD_BITS / 2;  // One tile index
    localparam int TILE_SHIFT    = 3;              // 8x8 pixel tiles
    localparam int ADDR_BITS     = 3;

    localparam logic [ADDR_BITS-1:0] REG_CTRL       = 3'd0;  // Bit 0 is display enable
    localparam logic [ADDR_BITS-1:0] REG_BG_COLOR   = 3'd1;
    localparam logic [ADDR_BITS-1:0] REG_RECT_COLOR = 3'd2;
    localparam logic [ADDR_BITS-1:0] REG_RECT_X     = 3'd3;
    localparam logic [ADDR_BITS-1:0] REG_RECT_Y     = 3'd4;

    typedef struct packed {
        logic [CHANNEL_BITS-1:0] red;
        logic [CHANNEL_BITS-1:0] green;
        logic [CHANNEL_BITS-1:0] blue;
        logic [CHANNEL_BITS-1:0] alpha;  // Never reaches the pins
    } vga_color_t;

    typedef struct packed {
        logic [SPAN_BITS-1:0] hi;  // Last tile, inclusive
        logic [SPAN_BITS-1:0] lo;  // First tile
    } vga_span_t;

    // Color registers and span registers share one write word
    typedef union packed {
        vga_color_t color;
        vga_span_t  span;
    } vga_reg_word_u;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ns

module vga_timing #(
    parameter int H_VIS_AREA_PXL    = 800,
    parameter int H_FRONT_PORCH_PXL = 40,
    parameter int H_SYNC_PULSE_PXL  = 128,
    parameter int H_BACK_PORCH_PXL  = 88,
    parameter int H_NUM_BITS        = 11,

    parameter int V_VIS_AREA_PXL    = 600,
    parameter int V_FRONT_PORCH_PXL = 1,
    parameter int V_SYNC_PULSE_PXL  = 4,
    parameter int V_BACK_PORCH_PXL  = 23,
    parameter int V_NUM_BITS        = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [H_NUM_BITS-1:0] h_count,
    output logic [V_NUM_BITS-1:0] v_count,
    output logic                  h_sync_raw,
    output logic                  v_sync_raw,
    output logic                  visible,
    output logic                  frame_end
);
    localparam int H_WHOLE_LINE_PXL = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL
                                    + H_SYNC_PULSE_PXL + H_BACK_PORCH_PXL;
    localparam int V_WHOLE_FRAME_PXL = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL
                                     + V_SYNC_PULSE_PXL + V_BACK_PORCH_PXL;

    localparam logic [H_NUM_BITS-1:0] H_LAST = H_NUM_BITS'(H_WHOLE_LINE_PXL - 1);
    localparam logic [H_NUM_BITS-1:0] H_VIS_END = H_NUM_BITS'(H_VIS_AREA_PXL);
    localparam logic [H_NUM_BITS-1:0] H_SYNC_START =
        H_NUM_BITS'(H_VIS_AREA_PXL + H_FRONT_PORCH_PXL);
    localparam logic [H_NUM_BITS-1:0] H_SYNC_END =
        H_NUM_BITS'(H_VIS_AREA_PXL + H_FRONT_PORCH_PXL + H_SYNC_PULSE_PXL);

    localparam logic [V_NUM_BITS-1:0] V_LAST = V_NUM_BITS'(V_WHOLE_FRAME_PXL - 1);
    localparam logic [V_NUM_BITS-1:0] V_VIS_END = V_NUM_BITS'(V_VIS_AREA_PXL);
    localparam logic [V_NUM_BITS-1:0] V_SYNC_START =
        V_NUM_BITS'(V_VIS_AREA_PXL + V_FRONT_PORCH_PXL);
    localparam logic [V_NUM_BITS-1:0] V_SYNC_END =
        V_NUM_BITS'(V_VIS_AREA_PXL + V_FRONT_PORCH_PXL + V_SYNC_PULSE_PXL);

    logic h_last;
    logic v_last;

    assign h_last    = (h_count == H_LAST);
    assign v_last    = (v_count == V_LAST);
    assign frame_end = h_last && v_last;  // Last pixel of the last line

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Vertical count advances once per line, on the same clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_count <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    assign h_sync_raw = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));  // Active low
    assign v_sync_raw = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));  // Active low
    assign visible    = (h_count < H_VIS_END) && (v_count < V_VIS_END);

endmodule

// File: src/vga_regs.sv
`timescale 1ns/1ns

module vga_regs
    import vga_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_valid,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  vga_reg_word_u        wr_data,
    input  logic                 frame_end,
    output logic                 wr_ready,
    output logic                 disp_enable,
    output vga_color_t           bg_color,
    output vga_color_t           rect_color,
    output vga_span_t            rect_x,
    output vga_span_t            rect_y
);
    logic       stg_enable;
    vga_color_t stg_bg_color;
    vga_color_t stg_rect_color;
    vga_span_t  stg_rect_x;
    vga_span_t  stg_rect_y;
    logic       wr_fire;

    assign wr_ready = !frame_end;  // Port stalls while live set loads
    assign wr_fire  = wr_valid && wr_ready;

    // Staging set, written by software at any time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_enable     <= 1'b0;
            stg_bg_color   <= '0;
            stg_rect_color <= '0;
            stg_rect_x     <= '0;
            stg_rect_y     <= '0;
        end else if (wr_fire) begin
            case (wr_addr)
                REG_CTRL: begin
                    stg_enable <= wr_data.span.lo[0];  // Enable in bit 0
                end
                REG_BG_COLOR: begin
                    stg_bg_color <= wr_data.color;
                end
                REG_RECT_COLOR: begin
                    stg_rect_color <= wr_data.color;
                end
                REG_RECT_X: begin
                    stg_rect_x <= wr_data.span;
                end
                REG_RECT_Y: begin
                    stg_rect_y <= wr_data.span;
                end
                default: begin
                    // Unused address, accepted and dropped
                end
            endcase
        end
    end

    // Live set changes only between frames, so no frame tears
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_enable <= 1'b0;
            bg_color    <= '0;
            rect_color  <= '0;
            rect_x      <= '0;
            rect_y      <= '0;
        end else if (frame_end) begin
            disp_enable <= stg_enable;
            bg_color    <= stg_bg_color;
            rect_color  <= stg_rect_color;
            rect_x      <= stg_rect_x;
            rect_y      <= stg_rect_y;
        end
    end

endmodule

// File: src/vga_pixel_gen.sv
`timescale 1ns/1ns

module vga_pixel_gen
    import vga_pkg::*;
#(
    parameter int H_NUM_BITS = 11,
    parameter int V_NUM_BITS = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [H_NUM_BITS-1:0]   h_count,
    input  logic [V_NUM_BITS-1:0]   v_count,
    input  logic                    h_sync_raw,
    input  logic                    v_sync_raw,
    input  logic                    visible,
    input  logic                    disp_enable,
    input  vga_color_t              bg_color,
    input  vga_color_t              rect_color,
    input  vga_span_t               rect_x,
    input  vga_span_t               rect_y,
    output logic [CHANNEL_BITS-1:0] red,
    output logic [CHANNEL_BITS-1:0] green,
    output logic [CHANNEL_BITS-1:0] blue,
    output logic                    h_sync,
    output logic                    v_sync,
    output logic [H_NUM_BITS-1:0]   h_pxl_count,
    output logic [V_NUM_BITS-1:0]   v_pxl_count
);
    // Wide enough for both a tile index and a span bound
    localparam int X_CMP_BITS = (H_NUM_BITS > SPAN_BITS) ? H_NUM_BITS : SPAN_BITS;
    localparam int Y_CMP_BITS = (V_NUM_BITS > SPAN_BITS) ? V_NUM_BITS : SPAN_BITS;

    logic [X_CMP_BITS-1:0] tile_col;
    logic [Y_CMP_BITS-1:0] tile_row;
    logic                  in_x;
    logic                  in_y;
    logic                  in_rect;
    vga_color_t            pix_color;

    assign tile_col = X_CMP_BITS'(h_count >> TILE_SHIFT);
    assign tile_row = Y_CMP_BITS'(v_count >> TILE_SHIFT);

    assign in_x = (tile_col >= X_CMP_BITS'(rect_x.lo)) && (tile_col <= X_CMP_BITS'(rect_x.hi));
    assign in_y = (tile_row >= Y_CMP_BITS'(rect_y.lo)) && (tile_row <= Y_CMP_BITS'(rect_y.hi));
    assign in_rect = in_x && in_y && (rect_color.alpha != '0);  // Zero alpha hides it

    always_comb begin
        if (!visible || !disp_enable) begin
            pix_color = '0;  // Blanking or display off
        end else if (in_rect) begin
            pix_color = rect_color;
        end else begin
            pix_color = bg_color;
        end
    end

    // Color, syncs and counts leave together, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red         <= '0;
            green       <= '0;
            blue        <= '0;
            h_sync      <= 1'b1;
            v_sync      <= 1'b1;
            h_pxl_count <= '0;
            v_pxl_count <= '0;
        end else begin
            red         <= pix_color.red;
            green       <= pix_color.green;
            blue        <= pix_color.blue;
            h_sync      <= h_sync_raw;
            v_sync      <= v_sync_raw;
            h_pxl_count <= h_count;
            v_pxl_count <= v_count;
        end
    end

endmodule

// File: src/vga_top.sv
`timescale 1ns/1ns

module vga_top
    import vga_pkg::*;
#(
    parameter int H_VIS_AREA_PXL    = 800,
    parameter int H_FRONT_PORCH_PXL = 40,
    parameter int H_SYNC_PULSE_PXL  = 128,
    parameter int H_BACK_PORCH_PXL  = 88,
    parameter int H_NUM_BITS        = 11,  // Holds one whole line

    parameter int V_VIS_AREA_PXL    = 600,
    parameter int V_FRONT_PORCH_PXL = 1,
    parameter int V_SYNC_PULSE_PXL  = 4,
    parameter int V_BACK_PORCH_PXL  = 23,
    parameter int V_NUM_BITS        = 10   // Holds one whole frame
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_valid,
    input  logic [ADDR_BITS-1:0]    wr_addr,
    input  vga_reg_word_u           wr_data,
    output logic                    wr_ready,
    output logic [CHANNEL_BITS-1:0] red,
    output logic [CHANNEL_BITS-1:0] green,
    output logic [CHANNEL_BITS-1:0] blue,
    output logic                    h_sync,
    output logic                    v_sync,
    output logic [H_NUM_BITS-1:0]   h_pxl_count,
    output logic [V_NUM_BITS-1:0]   v_pxl_count
);
    logic [H_NUM_BITS-1:0] h_count;
    logic [V_NUM_BITS-1:0] v_count;
    logic                  h_sync_raw;
    logic                  v_sync_raw;
    logic                  visible;
    logic                  frame_end;
    logic                  disp_enable;
    vga_color_t            bg_color;
    vga_color_t            rect_color;
    vga_span_t             rect_x;
    vga_span_t             rect_y;

    vga_timing #(
        .H_VIS_AREA_PXL    (H_VIS_AREA_PXL),
        .H_FRONT_PORCH_PXL (H_FRONT_PORCH_PXL),
        .H_SYNC_PULSE_PXL  (H_SYNC_PULSE_PXL),
        .H_BACK_PORCH_PXL  (H_BACK_PORCH_PXL),
        .H_NUM_BITS        (H_NUM_BITS),
        .V_VIS_AREA_PXL    (V_VIS_AREA_PXL),
        .V_FRONT_PORCH_PXL (V_FRONT_PORCH_PXL),
        .V_SYNC_PULSE_PXL  (V_SYNC_PULSE_PXL),
        .V_BACK_PORCH_PXL  (V_BACK_PORCH_PXL),
        .V_NUM_BITS        (V_NUM_BITS)
    ) vga_timing_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .visible    (visible),
        .frame_end  (frame_end)
    );

    vga_regs vga_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .frame_end   (frame_end),
        .wr_ready    (wr_ready),
        .disp_enable (disp_enable),
        .bg_color    (bg_color),
        .rect_color  (rect_color),
        .rect_x      (rect_x),
        .rect_y      (rect_y)
    );

    vga_pixel_gen #(
        .H_NUM_BITS (H_NUM_BITS),
        .V_NUM_BITS (V_NUM_BITS)
    ) vga_pixel_gen_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .h_count     (h_count),
        .v_count     (v_count),
        .h_sync_raw  (h_sync_raw),
        .v_sync_raw  (v_sync_raw),
        .visible     (visible),
        .disp_enable (disp_enable),
        .bg_color    (bg_color),
        .rect_color  (rect_color),
        .rect_x      (rect_x),
        .rect_y      (rect_y),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .h_pxl_count (h_pxl_count),
        .v_pxl_count (v_pxl_count)
    );

endmodule

// File: sim/vga_asserts.sv
`timescale 1ns/1ns

module vga_asserts #(
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_END   = 74,
    parameter int V_SYNC_START = 33,
    parameter int V_SYNC_END   = 35,
    parameter int H_VIS        = 64,
    parameter int V_VIS        = 32
) (
    input logic        clk,
    input logic        rst_n,
    input logic        h_sync,
    input logic        v_sync,
    input logic [31:0] h_cnt,
    input logic [31:0] v_cnt,
    input logic [11:0] rgb,
    input logic        wr_valid,
    input logic        wr_ready,
    input logic [2:0]  wr_addr,
    input logic [15:0] wr_data
);
    hsync_window: assert property (@(posedge clk) disable iff (!rst_n)
        !h_sync |-> (h_cnt >= H_SYNC_START && h_cnt < H_SYNC_END))
        else $error("h_sync low outside its window");

    vsync_window: assert property (@(posedge clk) disable iff (!rst_n)
        !v_sync |-> (v_cnt >= V_SYNC_START && v_cnt < V_SYNC_END))
        else $error("v_sync low outside its window");

    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (h_cnt >= H_VIS || v_cnt >= V_VIS) |-> (rgb == 12'h000))
        else $error("color not black in blanking");

    // Master must hold a stalled write
    write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_addr) && $stable(wr_data)))
        else $error("write dropped or changed while stalled");

endmodule

bind vga_top vga_asserts #(
    .H_SYNC_START (H_VIS_AREA_PXL + H_FRONT_PORCH_PXL),
    .H_SYNC_END   (H_VIS_AREA_PXL + H_FRONT_PORCH_PXL + H_SYNC_PULSE_PXL),
    .V_SYNC_START (V_VIS_AREA_PXL + V_FRONT_PORCH_PXL),
    .V_SYNC_END   (V_VIS_AREA_PXL + V_FRONT_PORCH_PXL + V_SYNC_PULSE_PXL),
    .H_VIS        (H_VIS_AREA_PXL),
    .V_VIS        (V_VIS_AREA_PXL)
) vga_asserts_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .h_sync   (h_sync),
    .v_sync   (v_sync),
    .h_cnt    (32'(h_pxl_count)),
    .v_cnt    (32'(v_pxl_count)),
    .rgb      ({red, green, blue}),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
);

// File: sim/vga_tb.sv
`timescale 1ns/1ns

module vga_tb;
    localparam int H_VIS = 64;
    localparam int H_FP = 4;
    localparam int H_SP = 6;
    localparam int H_BP = 4;
    localparam int V_VIS = 32;
    localparam int V_FP = 1;
    localparam int V_SP = 2;
    localparam int V_BP = 3;
    localparam int H_TOTAL = H_VIS + H_FP + H_SP + H_BP;  // 78
    localparam int V_TOTAL = V_VIS + V_FP + V_SP + V_BP;  // 38
    localparam int MAX_S = 64;

    logic        clk;
    logic        rst_n;
    logic        wr_valid;
    logic [2:0]  wr_addr;
    logic [15:0] wr_data;
    logic        wr_ready;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        h_sync;
    logic        v_sync;
    logic [6:0]  h_pxl_count;
    logic [5:0]  v_pxl_count;

    // Reference model of the staging and live configuration
    logic        stg_en;
    logic        live_en;
    logic [15:0] stg_bg;
    logic [15:0] live_bg;
    logic [15:0] stg_rc;
    logic [15:0] live_rc;
    logic [15:0] stg_rx;
    logic [15:0] live_rx;
    logic [15:0] stg_ry;
    logic [15:0] live_ry;

    int          frame_cnt;
    int          cyc;
    int          limit;
    int          n_samples;
    int          hits;
    int          s_frame [MAX_S];
    int          s_x [MAX_S];
    int          s_y [MAX_S];
    logic [11:0] s_rgb [MAX_S];
    bit          s_done [MAX_S];
    logic [15:0] lfsr;
    int          cnt_h;
    int          cnt_v;
    int          exp_h;
    int          exp_v;

    vga_top #(
        .H_VIS_AREA_PXL (H_VIS), .H_FRONT_PORCH_PXL (H_FP),
        .H_SYNC_PULSE_PXL (H_SP), .H_BACK_PORCH_PXL (H_BP), .H_NUM_BITS (7),
        .V_VIS_AREA_PXL (V_VIS), .V_FRONT_PORCH_PXL (V_FP),
        .V_SYNC_PULSE_PXL (V_SP), .V_BACK_PORCH_PXL (V_BP), .V_NUM_BITS (6)
    ) vga_top_inst (
        .clk (clk), .rst_n (rst_n), .wr_valid (wr_valid), .wr_addr (wr_addr),
        .wr_data (wr_data), .wr_ready (wr_ready), .red (red), .green (green),
        .blue (blue), .h_sync (h_sync), .v_sync (v_sync),
        .h_pxl_count (h_pxl_count), .v_pxl_count (v_pxl_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [11:0] expected_rgb(input int h, input int v);
        int col;
        int row;
        col = h >> 3;
        row = v >> 3;
        if (h >= H_VIS || v >= V_VIS || !live_en) return 12'h000;
        if (col >= live_rx[7:0] && col <= live_rx[15:8] && row >= live_ry[7:0]
            && row <= live_ry[15:8] && live_rc[3:0] != 4'h0) return live_rc[15:4];
        return live_bg[15:4];
    endfunction

    task automatic stage_write(input logic [2:0] a, input logic [15:0] d);
        case (a)
            3'd0: stg_en = d[0];
            3'd1: stg_bg = d;
            3'd2: stg_rc = d;
            3'd3: stg_rx = d;
            3'd4: stg_ry = d;
            default: ;  // Ignored by the DUT too
        endcase
    endtask

    task automatic do_write(input logic [2:0] a, input logic [15:0] d, input bit at_end);
        int idle;
        int stalls;
        idle = 0;
        stalls = 0;
        if (at_end) begin
            while (!(h_pxl_count == 7'(H_TOTAL - 2) && v_pxl_count == 6'(V_TOTAL - 1))) begin
                @(posedge clk);
                #1;
            end
        end else begin
            while (v_pxl_count < 6'(V_VIS)) begin  // Vertical blanking only
                @(posedge clk);
                #1;
            end
            idle[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            idle[1] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
        wr_valid = 1'b1;
        wr_addr = a;
        wr_data = d;
        while (!wr_ready) begin
            stalls++;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        stage_write(a, d);
        #1;
        wr_valid = 1'b0;
        if (at_end) check_value("wr_stall_cycles", stalls, 1);
    endtask

    // Expected output counts trail the line and frame counters by one cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            cnt_h = 0;
            cnt_v = 0;
            exp_h = 0;
            exp_v = 0;
        end else begin
            exp_h = cnt_h;
            exp_v = cnt_v;
            if (cnt_h == H_TOTAL - 1) begin
                cnt_h = 0;
                cnt_v = (cnt_v == V_TOTAL - 1) ? 0 : cnt_v + 1;
            end else begin
                cnt_h++;
            end
        end
    end

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        int h;
        int v;
        h = int'(h_pxl_count);
        v = int'(v_pxl_count);
        if (rst_n) begin
            check_value("h_pxl_count", h_pxl_count, exp_h);
            check_value("v_pxl_count", v_pxl_count, exp_v);
            check_value("h_sync", h_sync, !(h >= H_VIS + H_FP && h < H_VIS + H_FP + H_SP));
            check_value("v_sync", v_sync, !(v >= V_VIS + V_FP && v < V_VIS + V_FP + V_SP));
            check_value("rgb", {red, green, blue}, expected_rgb(h, v));
            for (int i = 0; i < n_samples; i++) begin
                if (!s_done[i] && s_frame[i] == frame_cnt && s_x[i] == h && s_y[i] == v) begin
                    check_value("rgb_sample", {red, green, blue}, s_rgb[i]);
                    s_done[i] = 1'b1;
                    hits++;
                end
            end
            if (h == H_TOTAL - 1 && v == V_TOTAL - 1) begin  // Live set loads here
                live_en = stg_en;
                live_bg = stg_bg;
                live_rc = stg_rc;
                live_rx = stg_rx;
                live_ry = stg_ry;
                frame_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int fd;
        int max_f;
        int a;
        int b;
        int c;
        logic [15:0] d;
        string line;
        byte cmd;
        rst_n = 1'b0;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        {stg_en, stg_bg, stg_rc, stg_rx, stg_ry} = '0;
        {live_en, live_bg, live_rc, live_rx, live_ry} = '0;
        frame_cnt = 0;
        cyc = 0;
        hits = 0;
        n_samples = 0;
        lfsr = 16'd55559;
        limit = 1000000;
        max_f = 0;
        fd = $fopen("sim/vga_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/vga_stim.txt");
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) > 0) begin  // First pass finds the frame count
            if (line.len() > 2 && line.getc(0) == "F") begin
                void'($sscanf(line.substr(2, line.len() - 1), "%d", a));
                if (a > max_f) max_f = a;
            end
        end
        $fclose(fd);
        limit = (max_f + 1) * H_TOTAL * V_TOTAL + 200;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("sim/vga_stim.txt", "r");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3) continue;
            cmd = line.getc(0);
            line = line.substr(2, line.len() - 1);
            if (cmd == "W" || cmd == "E") begin
                void'($sscanf(line, "%h %h", a, d));
                do_write(3'(a), d, cmd == "E");
            end else if (cmd == "S") begin
                void'($sscanf(line, "%d %d %d %h", a, b, c, d));
                s_frame[n_samples] = a;
                s_x[n_samples] = b;
                s_y[n_samples] = c;
                s_rgb[n_samples] = d[11:0];
                s_done[n_samples] = 1'b0;
                n_samples++;
            end else if (cmd == "F") begin
                void'($sscanf(line, "%d", a));
                while (frame_cnt <= a) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        $fclose(fd);
        check_value("samples_seen", hits, n_samples);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: sources.f
src/vga_pkg.sv
src/vga_timing.sv
src/vga_regs.sv
src/vga_pixel_gen.sv
src/vga_top.sv
sim/vga_asserts.sv
sim/vga_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the VGA testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module vga_tb -f sources.f -o vga_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vga_sim > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

// File: sim/vga_stim.txt
# W addr data | E addr data (issued in the frame_end cycle) : hex register write
# S frame x y rgb : expected color, frame x y decimal, rgb hex | F n : run past frame n
W 0 0001
W 1 3A50
F 0
S 1 0 0 3A5
S 1 63 31 3A5
S 1 64 0 000
S 1 0 32 000
W 2 C1EF
W 3 0502
W 4 0201
S 2 16 8 C1E
S 2 47 23 C1E
S 2 15 8 3A5
S 2 48 8 3A5
S 2 16 7 3A5
S 2 16 24 3A5
S 2 0 0 3A5
F 1
W 2 C1E0
S 3 16 8 3A5
S 3 47 23 3A5
F 2
W 0 0000
S 4 0 0 000
S 4 30 15 000
F 3
W 0 0001
E 1 7770
S 5 0 0 3A5
S 6 0 0 777
F 5
W 5 FFFF
W 6 0000
W 7 1234
S 7 0 0 777
S 7 20 10 777
S 7 64 0 000
F 7
